//--- list.f
decode_pkg.sv
decode_ctrl.sv
decode_imm.sv
decode_regs.sv
decode_perf.sv
decode_top.sv
decode_props.sv
tb_decode.sv

//--- Bender.yml
package:
  name: decode

sources:
  - decode_pkg.sv
  - decode_ctrl.sv
  - decode_imm.sv
  - decode_regs.sv
  - decode_perf.sv
  - decode_top.sv
  - target: test
    files:
      - decode_props.sv
      - tb_decode.sv

//--- tb_decode.sv
`timescale 1ns/1ps

module tb_decode;
    import decode_pkg::*;

    localparam int ALU_N       = 8;
    localparam int PERF_N      = 12;
    localparam int TEST_CYCLES = 2 + 2 * ALU_N + 11 + 14 + 7 + 3 + PERF_N + 2;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 50) * 20;

    logic       clk;
    logic       reset;
    logic       fetch_valid;
    fetch_rsp_t fetch_rsp;
    logic       fetch_ready;
    logic       dec_valid;
    decode_t    dec;
    logic       dec_ready;
    logic       wstall_valid;
    wid_t       wstall_wid;
    logic       wstall_stalled;
    logic       join_valid;
    wid_t       join_wid;
    perf_ctr_t  perf_loads;
    perf_ctr_t  perf_stores;
    perf_ctr_t  perf_branches;

    logic [15:0] lfsr_state;
    int          errors;
    int          checks;
    int          errors_at_start;
    string       cur_test;

    decode_top u_decode_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400; // Taps 16,14,13,11
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic int count_ones(tmask_t m);
        int c;
        c = 0;
        for (int i = 0; i < NUM_THREADS; i++)
            c += m[i];
        return c;
    endfunction

    function automatic word_t sext(word_t v, int bits);
        word_t mask;
        mask = 32'hFFFF_FFFF << bits;
        return v[bits-1] ? (v | mask) : (v & ~mask);
    endfunction

    function automatic op_t alu_op(logic [2:0] f3, logic alt);
        case (f3)
            3'h0: return alt ? ALU_SUB : ALU_ADD;
            3'h1: return ALU_SLL;
            3'h2: return ALU_SLT;
            3'h3: return ALU_SLTU;
            3'h4: return ALU_XOR;
            3'h5: return alt ? ALU_SRA : ALU_SRL;
            3'h6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    task automatic check(string field, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s %s: expected %0h, actual %0h",
                     cur_test, field, expected, actual);
        end
    endtask

    task automatic start_test(string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        $display("%s finished with %0d errors", cur_test, errors - errors_at_start);
    endtask

    // Inputs change 2 ns after the edge, outputs are read 5 ns later
    task automatic drive(logic valid, word_t instr, tmask_t tmask = '1,
                         wid_t wid = '0, logic ready = 1'b1);
        @(posedge clk);
        #2;
        fetch_valid     = valid;
        dec_ready       = ready;
        fetch_rsp.instr = instr;
        fetch_rsp.tmask = tmask;
        fetch_rsp.wid   = wid;
        fetch_rsp.pc    = rand_bits(30) << 2;
        fetch_rsp.uuid  = fetch_rsp.uuid + 1'b1;
        #5;
    endtask

    // Fetch side fields carried straight through to the decode output
    task automatic check_passthru();
        check("uuid", fetch_rsp.uuid, dec.uuid);
        check("wid", fetch_rsp.wid, dec.wid);
        check("tmask", fetch_rsp.tmask, dec.tmask);
        check("pc", fetch_rsp.pc, dec.pc);
    endtask

    task automatic check_fields(ex_type_t ex, op_t op, mod_t md, logic pc_sel,
                                logic imm_sel, word_t imm);
        check("ex_type", ex, dec.ex_type);
        check("op_type", op, dec.op_type);
        check("op_mod", md, dec.op_mod);
        check("use_pc", pc_sel, dec.use_pc);
        check("use_imm", imm_sel, dec.use_imm);
        check("imm", imm, dec.imm);
        check_passthru();
    endtask

    task automatic check_regs(reg_num_t rd, reg_num_t rs1, reg_num_t rs2, logic wb);
        check("rd", rd, dec.rd);
        check("rs1", rs1, dec.rs1);
        check("rs2", rs2, dec.rs2);
        check("wb", wb, dec.wb);
    endtask

    task automatic test_alu();
        logic [2:0]  f3;
        reg_num_t    rd;
        reg_num_t    rs1;
        reg_num_t    rs2;
        logic [11:0] imm12;
        logic        alt;
        logic        shift;
        word_t       exp_imm;
        start_test("alu_decode");
        for (int i = 0; i < ALU_N; i++) begin
            f3    = rand_bits(3);
            rd    = rand_bits(5);
            rs1   = rand_bits(5);
            rs2   = rand_bits(5);
            alt   = rand_bits(1);
            imm12 = rand_bits(12);
            shift = (f3 == 3'h1) || (f3 == 3'h5);
            if (shift)
                imm12 = {1'b0, alt && (f3 == 3'h5), 5'd0, imm12[4:0]};
            exp_imm = shift ? {27'd0, imm12[4:0]} : sext({20'd0, imm12}, 12);
            drive(1'b1, {imm12, rs1, f3, rd, OPC_I});
            check_fields(EX_ALU, alu_op(f3, (f3 == 3'h5) && imm12[10]), 3'd0, 1'b0, 1'b1,
                         exp_imm);
            check_regs(rd, rs1, 5'd0, rd != 5'd0);
            // Register form, func7 bit 5 only where it is legal
            alt = alt && (f3 == 3'h0 || f3 == 3'h5);
            drive(1'b1, {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OPC_R});
            check_fields(EX_ALU, alu_op(f3, alt), 3'd0, 1'b0, 1'b0, 32'd0);
            check_regs(rd, rs1, rs2, rd != 5'd0);
            check("wstall_stalled", 1'b0, wstall_stalled);
        end
        finish_test();
    endtask

    task automatic test_transfers();
        logic [2:0]  br_f3 [6] = '{3'h0, 3'h1, 3'h4, 3'h5, 3'h6, 3'h7};
        op_t         br_ops [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
        logic [19:0] u20;
        logic [11:0] b;
        logic [11:0] imm12;
        reg_num_t    rd;
        reg_num_t    rs1;
        reg_num_t    rs2;
        start_test("control_transfer");
        u20 = rand_bits(20);
        rd  = rand_bits(5);
        drive(1'b1, {u20, rd, OPC_LUI});
        check_fields(EX_ALU, ALU_LUI, 3'd0, 1'b0, 1'b1, {u20, 12'd0});
        check("wstall_stalled", 1'b0, wstall_stalled);
        drive(1'b1, {u20, rd, OPC_AUIPC});
        check_fields(EX_ALU, ALU_AUIPC, 3'd0, 1'b1, 1'b1, {u20, 12'd0});
        // JAL offset bits 20:1 scattered over the J format
        u20 = rand_bits(20);
        drive(1'b1, {u20[19], u20[9:0], u20[10], u20[18:11], rd, OPC_JAL});
        check_fields(EX_ALU, BR_JAL, 3'd1, 1'b1, 1'b1, sext({11'd0, u20, 1'b0}, 21));
        check("wstall_valid", 1'b1, wstall_valid);
        check("wstall_stalled", 1'b1, wstall_stalled);
        imm12 = rand_bits(12);
        rs1   = rand_bits(5);
        drive(1'b1, {imm12, rs1, 3'h0, rd, OPC_JALR});
        check_fields(EX_ALU, BR_JALR, 3'd1, 1'b0, 1'b1, sext({20'd0, imm12}, 12));
        check_regs(rd, rs1, 5'd0, rd != 5'd0);
        check("wstall_stalled", 1'b1, wstall_stalled);
        for (int i = 0; i < 6; i++) begin
            b   = rand_bits(12); // Offset bits 12:1
            rs1 = rand_bits(5);
            rs2 = rand_bits(5);
            drive(1'b1, {b[11], b[9:4], rs2, rs1, br_f3[i], b[3:0], b[10], OPC_B});
            check_fields(EX_ALU, br_ops[i], 3'd1, 1'b1, 1'b1, sext({19'd0, b, 1'b0}, 13));
            check_regs(5'd0, rs1, rs2, 1'b0);
            check("wstall_valid", 1'b1, wstall_valid);
            check("wstall_stalled", 1'b1, wstall_stalled);
        end
        drive(1'b1, {7'd0, rs2, rs1, 3'h0, rd, OPC_R});
        check("wstall_valid", 1'b1, wstall_valid);
        check("wstall_stalled", 1'b0, wstall_stalled);
        finish_test();
    endtask

    task automatic test_mem_sys();
        logic [2:0]  ld_f3 [5] = '{3'h0, 3'h1, 3'h2, 3'h4, 3'h5};
        logic [11:0] imm12;
        logic [2:0]  f3;
        reg_num_t    rd;
        reg_num_t    rs1;
        reg_num_t    rs2;
        start_test("memory_system");
        for (int i = 0; i < 5; i++) begin
            imm12 = rand_bits(12);
            rs1   = rand_bits(5);
            rd    = (i == 0) ? 5'd0 : 5'(rand_bits(5));
            drive(1'b1, {imm12, rs1, ld_f3[i], rd, OPC_L});
            check_fields(EX_LSU, {1'b0, ld_f3[i]}, 3'd0, 1'b0, 1'b0, sext({20'd0, imm12}, 12));
            check_regs(rd, rs1, 5'd0, rd != 5'd0);
        end
        for (int i = 0; i < 3; i++) begin
            imm12 = rand_bits(12);
            rs1   = rand_bits(5);
            rs2   = rand_bits(5);
            drive(1'b1, {imm12[11:5], rs2, rs1, 3'(i), imm12[4:0], OPC_S});
            check_fields(EX_LSU, {1'b1, 3'(i)}, 3'd0, 1'b0, 1'b0, sext({20'd0, imm12}, 12));
            check_regs(5'd0, rs1, rs2, 1'b0);
        end
        // CSR address in imm 11:0, zimm or rs1 field in 16:12
        for (int i = 0; i < 4; i++) begin
            imm12 = rand_bits(12);
            rs1   = rand_bits(5);
            rd    = rand_bits(5);
            f3    = rand_bits(3);
            if (f3[1:0] == 2'b00)
                f3[1:0] = 2'b01;
            drive(1'b1, {imm12, rs1, f3, rd, OPC_SYS});
            check_fields(EX_CSR, {2'b00, f3[1:0]}, 3'd0, 1'b0, f3[2], {15'd0, rs1, imm12});
            check_regs(rd, f3[2] ? 5'd0 : rs1, 5'd0, rd != 5'd0);
        end
        drive(1'b1, 32'h0000_0073); // ECALL
        check_fields(EX_ALU, BR_ECALL, 3'd1, 1'b1, 1'b1, 32'd4);
        check_regs(5'd0, 5'd0, 5'd0, 1'b0);
        check("wstall_stalled", 1'b1, wstall_stalled);
        drive(1'b1, 32'h3020_0073); // MRET
        check_fields(EX_ALU, BR_MRET, 3'd1, 1'b1, 1'b1, 32'd4);
        finish_test();
    endtask

    task automatic test_warp();
        op_t        exp_ops [7] = '{GPU_TMC, GPU_PRED, GPU_WSPAWN, GPU_SPLIT, GPU_JOIN,
                                    GPU_BAR, LSU_LW};
        logic       stalls [7] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        wid_t       wid;
        reg_num_t   rs2;
        logic [2:0] f3;
        start_test("warp_control");
        for (int i = 0; i < 7; i++) begin
            wid    = rand_bits(2);
            rs2    = rand_bits(5);
            rs2[0] = (i == 1); // PRED shares func3 0 with TMC
            f3     = (i == 0) ? 3'h0 : 3'(i - 1);
            drive(1'b1, {7'd0, rs2, 5'd3, f3, 5'd0, OPC_GPGPU}, '1, wid);
            check("ex_type", (i == 6) ? EX_LSU : EX_GPU, dec.ex_type);
            check("op_type", exp_ops[i], dec.op_type);
            check("op_mod", (i == 6) ? 3'd2 : 3'd0, dec.op_mod);
            check_passthru();
            check("wstall_valid", 1'b1, wstall_valid);
            check("wstall_wid", wid, wstall_wid);
            check("wstall_stalled", stalls[i], wstall_stalled);
            check("join_valid", i == 4, join_valid);
            if (i == 4)
                check("join_wid", wid, join_wid);
        end
        finish_test();
    endtask

    task automatic test_backpressure();
        perf_ctr_t l0;
        perf_ctr_t s0;
        perf_ctr_t b0;
        start_test("back_pressure");
        l0 = perf_loads;
        s0 = perf_stores;
        b0 = perf_branches;
        drive(1'b1, {12'h004, 5'd1, 3'h2, 5'd2, OPC_L}, '1, 2'd1, 1'b0);
        check("fetch_ready", 1'b0, fetch_ready);
        check("dec_valid", 1'b1, dec_valid);
        check("wstall_valid", 1'b0, wstall_valid);
        check("ex_type", EX_LSU, dec.ex_type);
        drive(1'b1, {17'd0, 3'h3, 5'd0, OPC_GPGPU}, '1, 2'd2, 1'b0);
        check("join_valid", 1'b0, join_valid);
        check("wstall_valid", 1'b0, wstall_valid);
        check("op_type", GPU_JOIN, dec.op_type);
        drive(1'b0, 32'd0);
        check("fetch_ready", 1'b1, fetch_ready);
        check("perf_loads", l0, perf_loads);
        check("perf_stores", s0, perf_stores);
        check("perf_branches", b0, perf_branches);
        finish_test();
    endtask

    task automatic test_perf();
        perf_ctr_t exp_l;
        perf_ctr_t exp_s;
        perf_ctr_t exp_b;
        tmask_t    tm;
        word_t     instr;
        int        kind;
        start_test("perf_counters");
        exp_l = perf_loads;
        exp_s = perf_stores;
        exp_b = perf_branches;
        for (int i = 0; i < PERF_N; i++) begin
            kind = rand_bits(3) % 5;
            tm   = rand_bits(NUM_THREADS);
            case (kind)
                0: begin
                    instr = {12'h010, 5'd1, 3'h2, 5'd2, OPC_L};
                    exp_l += count_ones(tm);
                end
                1: begin
                    instr = {7'd0, 5'd3, 5'd1, 3'h2, 5'd0, OPC_S};
                    exp_s += count_ones(tm);
                end
                2: begin
                    instr = {7'd0, 5'd3, 5'd1, 3'h0, 5'd8, OPC_B};
                    exp_b += count_ones(tm);
                end
                3: instr = {25'd0, OPC_FENCE};
                default: instr = {12'd0, 5'd1, 3'h5, 5'd0, OPC_GPGPU}; // Counts nowhere
            endcase
            drive(1'b1, instr, tm);
            check_passthru();
        end
        drive(1'b0, 32'd0);
        check("perf_loads", exp_l, perf_loads);
        check("perf_stores", exp_s, perf_stores);
        check("perf_branches", exp_b, perf_branches);
        finish_test();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        lfsr_state  = 16'd44;
        errors      = 0;
        checks      = 0;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_rsp   = '0;
        dec_ready   = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        test_alu();
        test_transfers();
        test_mem_sys();
        test_warp();
        test_backpressure();
        test_perf();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- decode_props.sv
`timescale 1ns/1ps

module decode_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  fetch_valid,
    input logic                  dec_ready,
    input logic                  dec_valid,
    input logic                  wstall_valid,
    input logic                  join_valid,
    input decode_pkg::perf_ctr_t perf_loads,
    input decode_pkg::perf_ctr_t perf_stores,
    input decode_pkg::perf_ctr_t perf_branches
);

    a_join_has_transfer: assert property (@(posedge clk) disable iff (reset)
        join_valid |-> wstall_valid)
        else $error("join notification without a transfer");

    a_wstall_on_fire: assert property (@(posedge clk) disable iff (reset)
        wstall_valid |-> (fetch_valid && dec_ready))
        else $error("warp stall notification without valid and ready");

    a_valid_passthru: assert property (@(posedge clk) disable iff (reset)
        dec_valid == fetch_valid)
        else $error("dec_valid differs from fetch_valid");

    // Counters only grow between resets
    a_ctr_monotonic: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (perf_loads >= $past(perf_loads)
                        && perf_stores >= $past(perf_stores)
                        && perf_branches >= $past(perf_branches)))
        else $error("a perf counter decreased");

endmodule

bind decode_top decode_props u_props (.*);

//--- decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid,
    input  decode_pkg::fetch_rsp_t fetch_rsp,
    output logic                   fetch_ready,
    output logic                   dec_valid,
    output decode_pkg::decode_t    dec,
    input  logic                   dec_ready,
    output logic                   wstall_valid,
    output decode_pkg::wid_t       wstall_wid,
    output logic                   wstall_stalled,
    output logic                   join_valid,
    output decode_pkg::wid_t       join_wid,
    output decode_pkg::perf_ctr_t  perf_loads,
    output decode_pkg::perf_ctr_t  perf_stores,
    output decode_pkg::perf_ctr_t  perf_branches
);
    import decode_pkg::*;

    logic      fire;
    dec_ctrl_t ctrl;

    assign fire        = fetch_valid && dec_ready;
    assign dec_valid   = fetch_valid;
    assign fetch_ready = dec_ready;

    assign dec.uuid  = fetch_rsp.uuid;
    assign dec.wid   = fetch_rsp.wid;
    assign dec.tmask = fetch_rsp.tmask;
    assign dec.pc    = fetch_rsp.pc;

    decode_ctrl u_ctrl (
        .instr          (fetch_rsp.instr),
        .fire           (fire),
        .ctrl           (ctrl),
        .ex_type        (dec.ex_type),
        .op_type        (dec.op_type),
        .op_mod         (dec.op_mod),
        .use_pc         (dec.use_pc),
        .use_imm        (dec.use_imm),
        .wstall_stalled (wstall_stalled),
        .join_hit       (join_valid)
    );

    decode_imm u_imm (
        .instr (fetch_rsp.instr),
        .fmt   (ctrl.imm_fmt),
        .imm   (dec.imm)
    );

    decode_regs u_regs (
        .instr (fetch_rsp.instr),
        .ctrl  (ctrl),
        .rd    (dec.rd),
        .rs1   (dec.rs1),
        .rs2   (dec.rs2),
        .wb    (dec.wb)
    );

    decode_perf u_perf (
        .clk      (clk),
        .reset    (reset),
        .fire     (fire),
        .dec      (dec),
        .loads    (perf_loads),
        .stores   (perf_stores),
        .branches (perf_branches)
    );

    // Every transfer reports the warp to the scheduler
    assign wstall_valid = fire;
    assign wstall_wid   = fetch_rsp.wid;
    assign join_wid     = fetch_rsp.wid;

endmodule

//--- decode_perf.sv
`timescale 1ns/1ps

module decode_perf (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fire,
    input  decode_pkg::decode_t   dec,
    output decode_pkg::perf_ctr_t loads,
    output decode_pkg::perf_ctr_t stores,
    output decode_pkg::perf_ctr_t branches
);
    import decode_pkg::*;

    tcount_t active;
    logic    is_mem;
    logic    is_branch;

    always_comb begin
        active = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            active = active + tcount_t'(dec.tmask[i]);
        end
    end

    // op_mod 0 excludes FENCE and the GPU load
    assign is_mem    = (dec.ex_type == EX_LSU) && (dec.op_mod == 3'd0);
    assign is_branch = (dec.ex_type == EX_ALU) && (dec.op_mod == 3'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            loads    <= '0;
            stores   <= '0;
            branches <= '0;
        end else if (fire) begin
            if (is_mem && !dec.op_type[3])
                loads <= loads + perf_ctr_t'(active);
            if (is_mem && dec.op_type[3])
                stores <= stores + perf_ctr_t'(active);
            if (is_branch)
                branches <= branches + perf_ctr_t'(active);
        end
    end

endmodule

//--- decode_regs.sv
`timescale 1ns/1ps

module decode_regs (
    input  decode_pkg::word_t     instr,
    input  decode_pkg::dec_ctrl_t ctrl,
    output decode_pkg::reg_num_t  rd,
    output decode_pkg::reg_num_t  rs1,
    output decode_pkg::reg_num_t  rs2,
    output logic                  wb
);
    import decode_pkg::*;

    reg_num_t rd_field;
    reg_num_t rs1_field;
    reg_num_t rs2_field;

    assign rd_field  = instr[11:7];
    assign rs1_field = instr[19:15];
    assign rs2_field = instr[24:20];

    assign rd  = ctrl.use_rd  ? rd_field  : '0;
    assign rs1 = ctrl.use_rs1 ? rs1_field : '0;
    assign rs2 = ctrl.use_rs2 ? rs2_field : '0;

    // No write back to x0
    assign wb = ctrl.use_rd && (rd_field != '0);

endmodule

//--- decode_imm.sv
`timescale 1ns/1ps

module decode_imm (
    input  decode_pkg::word_t    instr,
    input  decode_pkg::imm_fmt_t fmt,
    output decode_pkg::word_t    imm
);
    import decode_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            IMM_I:     imm = {{20{sign}}, instr[31:20]};
            IMM_SHAMT: imm = {27'd0, instr[24:20]};
            IMM_S:     imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B:     imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U:     imm = {instr[31:12], 12'd0};
            IMM_J:     imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            // Address low, zimm above it
            IMM_CSR:   imm = {15'd0, instr[19:15], instr[31:20]};
            IMM_FOUR:  imm = 32'd4;
            default:   imm = '0;
        endcase
    end

endmodule

//--- decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
    input  decode_pkg::word_t     instr,
    input  logic                  fire,
    output decode_pkg::dec_ctrl_t ctrl,
    output decode_pkg::ex_type_t  ex_type,
    output decode_pkg::op_t       op_type,
    output decode_pkg::mod_t      op_mod,
    output logic                  use_pc,
    output logic                  use_imm,
    output logic                  wstall_stalled,
    output logic                  join_hit
);
    import decode_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  func3;
    logic [6:0]  func7;
    logic [11:0] u_12;
    logic        is_join;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign u_12   = instr[31:20];

    always_comb begin
        ctrl           = '0;
        ex_type        = EX_NONE;
        op_type        = '0;
        op_mod         = '0;
        use_pc         = 1'b0;
        use_imm        = 1'b0;
        wstall_stalled = 1'b0;
        is_join        = 1'b0;

        case (opcode)
            OPC_I, OPC_R: begin
                ex_type      = EX_ALU;
                ctrl.use_rd  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                case (func3)
                    3'h0: op_type = (opcode == OPC_R && func7[5]) ? ALU_SUB : ALU_ADD;
                    3'h1: op_type = ALU_SLL;
                    3'h2: op_type = ALU_SLT;
                    3'h3: op_type = ALU_SLTU;
                    3'h4: op_type = ALU_XOR;
                    3'h5: op_type = func7[5] ? ALU_SRA : ALU_SRL;
                    3'h6: op_type = ALU_OR;
                    default: op_type = ALU_AND;
                endcase
                if (opcode == OPC_I) begin
                    use_imm      = 1'b1;
                    ctrl.imm_fmt = (func3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;
                end else begin
                    ctrl.use_rs2 = 1'b1;
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                ex_type      = EX_ALU;
                op_type      = (opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                use_imm      = 1'b1;
                use_pc       = (opcode == OPC_AUIPC);
                ctrl.imm_fmt = IMM_U;
                ctrl.use_rd  = 1'b1;
            end
            OPC_JAL: begin
                ex_type        = EX_ALU;
                op_type        = BR_JAL;
                op_mod         = 3'd1;
                use_imm        = 1'b1;
                use_pc         = 1'b1;
                wstall_stalled = 1'b1;
                ctrl.imm_fmt   = IMM_J;
                ctrl.use_rd    = 1'b1;
            end
            OPC_JALR: begin
                ex_type        = EX_ALU;
                op_type        = BR_JALR;
                op_mod         = 3'd1;
                use_imm        = 1'b1;
                wstall_stalled = 1'b1;
                ctrl.imm_fmt   = IMM_I;
                ctrl.use_rd    = 1'b1;
                ctrl.use_rs1   = 1'b1;
            end
            OPC_B: begin
                ex_type = EX_ALU;
                case (func3)
                    3'h0: op_type = BR_EQ;
                    3'h1: op_type = BR_NE;
                    3'h4: op_type = BR_LT;
                    3'h5: op_type = BR_GE;
                    3'h6: op_type = BR_LTU;
                    3'h7: op_type = BR_GEU;
                    default: ;
                endcase
                op_mod         = 3'd1;
                use_imm        = 1'b1;
                use_pc         = 1'b1;
                wstall_stalled = 1'b1;
                ctrl.imm_fmt   = IMM_B;
                ctrl.use_rs1   = 1'b1;
                ctrl.use_rs2   = 1'b1;
            end
            OPC_L: begin
                ex_type      = EX_LSU;
                op_type      = {1'b0, func3};
                ctrl.imm_fmt = IMM_I;
                ctrl.use_rd  = 1'b1;
                ctrl.use_rs1 = 1'b1;
            end
            OPC_S: begin
                ex_type      = EX_LSU;
                op_type      = {1'b1, func3}; // Bit 3 marks a store
                ctrl.imm_fmt = IMM_S;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
            end
            OPC_FENCE: begin
                ex_type = EX_LSU;
                op_mod  = 3'd1;
            end
            OPC_SYS: begin
                if (func3[1:0] != 2'b00) begin
                    ex_type      = EX_CSR;
                    op_type      = {2'b00, func3[1:0]};
                    use_imm      = func3[2]; // rs1 field is an immediate
                    ctrl.imm_fmt = IMM_CSR;
                    ctrl.use_rd  = 1'b1;
                    ctrl.use_rs1 = ~func3[2];
                end else begin
                    ex_type = EX_ALU;
                    case (u_12)
                        12'h000: op_type = BR_ECALL;
                        12'h001: op_type = BR_EBREAK;
                        12'h002: op_type = BR_URET;
                        12'h102: op_type = BR_SRET;
                        12'h302: op_type = BR_MRET;
                        default: ;
                    endcase
                    op_mod         = 3'd1;
                    use_imm        = 1'b1;
                    use_pc         = 1'b1;
                    wstall_stalled = 1'b1;
                    ctrl.imm_fmt   = IMM_FOUR; // Return address is pc + 4
                    ctrl.use_rd    = 1'b1;
                end
            end
            OPC_GPGPU: begin
                ex_type = EX_GPU;
                case (func3)
                    3'h0: begin
                        op_type        = instr[20] ? GPU_PRED : GPU_TMC;
                        wstall_stalled = 1'b1;
                        ctrl.use_rs1   = 1'b1;
                    end
                    3'h1: begin
                        op_type      = GPU_WSPAWN;
                        ctrl.use_rs1 = 1'b1;
                        ctrl.use_rs2 = 1'b1;
                    end
                    3'h2: begin
                        op_type        = GPU_SPLIT;
                        wstall_stalled = 1'b1;
                        ctrl.use_rs1   = 1'b1;
                    end
                    3'h3: begin
                        op_type = GPU_JOIN;
                        is_join = 1'b1;
                    end
                    3'h4: begin
                        op_type        = GPU_BAR;
                        wstall_stalled = 1'b1;
                        ctrl.use_rs1   = 1'b1;
                        ctrl.use_rs2   = 1'b1;
                    end
                    3'h5: begin
                        ex_type      = EX_LSU; // GPU load goes to the LSU
                        op_type      = LSU_LW;
                        op_mod       = 3'd2;
                        ctrl.use_rs1 = 1'b1;
                    end
                    default: ex_type = EX_NONE;
                endcase
            end
            default: ;
        endcase
    end

    assign join_hit = is_join && fire;

endmodule

//--- decode_pkg.sv
package decode_pkg;

    localparam int NUM_THREADS   = 4;
    localparam int NUM_WARPS     = 4;
    localparam int UUID_BITS     = 16;
    localparam int PERF_CTR_BITS = 32;

    typedef logic [31:0]                        word_t;
    typedef logic [4:0]                         reg_num_t;
    typedef logic [$clog2(NUM_WARPS)-1:0]       wid_t;
    typedef logic [NUM_THREADS-1:0]             tmask_t;
    typedef logic [UUID_BITS-1:0]               uuid_t;
    typedef logic [3:0]                         op_t;
    typedef logic [2:0]                         mod_t;
    typedef logic [PERF_CTR_BITS-1:0]           perf_ctr_t;
    typedef logic [$clog2(NUM_THREADS+1)-1:0]   tcount_t;

    // Five units need three bits
    typedef enum logic [2:0] {
        EX_NONE = 3'd0,
        EX_ALU  = 3'd1,
        EX_LSU  = 3'd2,
        EX_CSR  = 3'd3,
        EX_GPU  = 3'd4
    } ex_type_t;

    // Nine formats need four bits
    typedef enum logic [3:0] {
        IMM_NONE  = 4'd0,
        IMM_I     = 4'd1,
        IMM_SHAMT = 4'd2,
        IMM_S     = 4'd3,
        IMM_B     = 4'd4,
        IMM_U     = 4'd5,
        IMM_J     = 4'd6,
        IMM_CSR   = 4'd7,
        IMM_FOUR  = 4'd8
    } imm_fmt_t;

    // ALU operations, op_mod 0
    localparam op_t ALU_ADD   = 4'd0;
    localparam op_t ALU_SUB   = 4'd1;
    localparam op_t ALU_SLL   = 4'd2;
    localparam op_t ALU_SLT   = 4'd3;
    localparam op_t ALU_SLTU  = 4'd4;
    localparam op_t ALU_XOR   = 4'd5;
    localparam op_t ALU_SRL   = 4'd6;
    localparam op_t ALU_SRA   = 4'd7;
    localparam op_t ALU_OR    = 4'd8;
    localparam op_t ALU_AND   = 4'd9;
    localparam op_t ALU_LUI   = 4'd10;
    localparam op_t ALU_AUIPC = 4'd11;

    // Control transfers, op_mod 1
    localparam op_t BR_EQ     = 4'd0;
    localparam op_t BR_NE     = 4'd1;
    localparam op_t BR_LT     = 4'd2;
    localparam op_t BR_GE     = 4'd3;
    localparam op_t BR_LTU    = 4'd4;
    localparam op_t BR_GEU    = 4'd5;
    localparam op_t BR_JAL    = 4'd6;
    localparam op_t BR_JALR   = 4'd7;
    localparam op_t BR_ECALL  = 4'd8;
    localparam op_t BR_EBREAK = 4'd9;
    localparam op_t BR_URET   = 4'd10;
    localparam op_t BR_SRET   = 4'd11;
    localparam op_t BR_MRET   = 4'd12;

    localparam op_t GPU_TMC    = 4'd0;
    localparam op_t GPU_PRED   = 4'd1;
    localparam op_t GPU_WSPAWN = 4'd2;
    localparam op_t GPU_SPLIT  = 4'd3;
    localparam op_t GPU_JOIN   = 4'd4;
    localparam op_t GPU_BAR    = 4'd5;

    localparam op_t LSU_LW = 4'b0010; // Word load, store bit clear

    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_L     = 7'b0000011;
    localparam logic [6:0] OPC_S     = 7'b0100011;
    localparam logic [6:0] OPC_FENCE = 7'b0001111;
    localparam logic [6:0] OPC_SYS   = 7'b1110011;
    localparam logic [6:0] OPC_GPGPU = 7'h6B;

    typedef struct packed {
        uuid_t  uuid;
        wid_t   wid;
        tmask_t tmask;
        word_t  pc;
        word_t  instr;
    } fetch_rsp_t;

    typedef struct packed {
        uuid_t    uuid;
        wid_t     wid;
        tmask_t   tmask;
        word_t    pc;
        ex_type_t ex_type;
        op_t      op_type;
        mod_t     op_mod;
        logic     wb;
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
        word_t    imm;
        logic     use_pc;
        logic     use_imm;
    } decode_t;

    typedef struct packed {
        imm_fmt_t imm_fmt;
        logic     use_rd;
        logic     use_rs1;
        logic     use_rs2;
    } dec_ctrl_t;

endpackage
